// ==== common/eeprom_pkg.sv ====
package eeprom_pkg;

    // byte address inside the 24C16 array, top 3 bits select the block
    typedef logic [10:0] eeprom_addr_t;

    typedef logic [7:0] byte_t;

    // operations handed from the sequencer to the byte engine
    typedef enum logic [1:0]
    {
        OP_START, // start or repeated start
        OP_STOP,
        OP_WRITE, // byte out, ack sampled
        OP_READ   // byte in, ack bit sent
    } byte_op_e;

    // single bit-time commands for the bit engine
    typedef enum logic [1:0]
    {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bit_cmd_e;

    typedef enum logic [3:0]
    {
        IDLE,
        W_START,
        W_CTRL,
        W_ADDR,
        W_DATA,
        R_RESTART,
        R_CTRL,
        R_DATA,
        STOP,
        DONE
    } seq_state_e;

    // device type code in the upper nibble of the control byte
    localparam logic [3:0] DEVICE_TYPE = 4'b1010;

endpackage

// ==== i2c_master/i2c_bit_engine.sv ====
`timescale 1ns/1ps

module i2c_bit_engine #(
    parameter int CLKS_PER_QUARTER = 2
)
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_valid,
    input  eeprom_pkg::bit_cmd_e cmd,
    input  logic                 bit_out,
    output logic                 bit_done,
    output logic                 bit_in,
    output logic                 scl,
    inout  wire                  sda
);

    localparam int QW = (CLKS_PER_QUARTER > 1) ? $clog2(CLKS_PER_QUARTER) : 1;
    localparam logic [QW-1:0] Q_LAST = QW'(CLKS_PER_QUARTER - 1);

    logic                 active;
    eeprom_pkg::bit_cmd_e cmd_r;
    logic                 bit_r;
    logic [QW-1:0]        q_cnt;
    logic [1:0]           phase;
    logic                 q_last;
    logic                 accept;
    logic                 update;
    logic [1:0]           phase_nxt;
    eeprom_pkg::bit_cmd_e cmd_nxt;
    logic                 bit_nxt;
    logic                 sda_low;

    // scl is high in the middle phases, stop leaves it high
    function automatic logic scl_level(eeprom_pkg::bit_cmd_e c, logic [1:0] ph);
        scl_level = (ph == 2'd1) || (ph == 2'd2) ||
                    ((c == eeprom_pkg::CMD_STOP) && (ph == 2'd3));
    endfunction

    function automatic logic sda_pull(eeprom_pkg::bit_cmd_e c, logic b, logic [1:0] ph);
        case (c)
            eeprom_pkg::CMD_START: sda_pull = ph[1];  // falls entering phase 2
            eeprom_pkg::CMD_STOP:  sda_pull = !ph[1]; // rises entering phase 2
            eeprom_pkg::CMD_WRITE: sda_pull = !b;
            default:               sda_pull = 1'b0;
        endcase
    endfunction

    assign q_last   = (q_cnt == Q_LAST);
    assign bit_done = active && (phase == 2'd3) && q_last;
    assign accept   = cmd_valid && (!active || bit_done);

    // open-drain, only ever pulled low
    assign sda = sda_low ? 1'b0 : 1'bz;

    always_comb
    begin
        update    = 1'b0;
        phase_nxt = phase + 2'd1;
        cmd_nxt   = cmd_r;
        bit_nxt   = bit_r;
        if (accept)
        begin
            update    = 1'b1;
            phase_nxt = 2'd0;
            cmd_nxt   = cmd;
            bit_nxt   = bit_out;
        end
        else if (active && q_last && (phase != 2'd3))
            update = 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            phase   <= 2'd0;
            q_cnt   <= '0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
        end
        else
        begin
            if (accept)
            begin
                active <= 1'b1;
                phase  <= 2'd0;
                q_cnt  <= '0;
            end
            else if (active)
            begin
                q_cnt <= q_last ? '0 : q_cnt + 1'b1;
                if (q_last)
                    phase <= phase + 2'd1;
                if (bit_done)
                    active <= 1'b0; // lines hold their last level
            end
            if (update)
            begin
                scl     <= scl_level(cmd_nxt, phase_nxt);
                sda_low <= sda_pull(cmd_nxt, bit_nxt, phase_nxt);
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cmd_r <= cmd;
            bit_r <= bit_out;
        end
        if (active && (phase == 2'd1) && q_last)
            bit_in <= sda; // scl high midpoint
    end

endmodule

// ==== i2c_master/i2c_byte_engine.sv ====
`timescale 1ns/1ps

module i2c_byte_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 op_valid,
    input  eeprom_pkg::byte_op_e op,
    input  eeprom_pkg::byte_t    tx_byte,
    input  logic                 ack_out,
    input  logic                 bit_done,
    input  logic                 bit_in,
    output logic                 op_done,
    output eeprom_pkg::byte_t    rx_byte,
    output logic                 ack_in,
    output logic                 cmd_valid,
    output eeprom_pkg::bit_cmd_e cmd,
    output logic                 bit_out
);

    eeprom_pkg::byte_op_e op_r;
    eeprom_pkg::byte_t    sh;        // tx and rx share the shifter
    logic                 ack_out_r;
    logic                 active;
    logic                 issue_r;   // first bit of the op pending
    logic [3:0]           cnt;       // index of next bit to issue
    logic [3:0]           nbits;
    logic                 start_op;
    logic                 last_done;

    assign start_op  = op_valid && !active;
    assign nbits     = ((op_r == eeprom_pkg::OP_START) || (op_r == eeprom_pkg::OP_STOP)) ?
                       4'd1 : 4'd9;
    assign last_done = active && bit_done && (cnt == nbits);
    assign cmd_valid = issue_r || (active && bit_done && (cnt != nbits));
    assign rx_byte   = sh;

    always_comb
    begin
        cmd     = eeprom_pkg::CMD_WRITE;
        bit_out = 1'b1;
        case (op_r)
            eeprom_pkg::OP_START:
                cmd = eeprom_pkg::CMD_START;
            eeprom_pkg::OP_STOP:
                cmd = eeprom_pkg::CMD_STOP;
            eeprom_pkg::OP_WRITE:
                if (cnt < 4'd8)
                    bit_out = sh[7];
                else
                    cmd = eeprom_pkg::CMD_READ; // release sda for slave ack
            default:
                if (cnt < 4'd8)
                    cmd = eeprom_pkg::CMD_READ;
                else
                    bit_out = ack_out_r;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            issue_r <= 1'b0;
            cnt     <= 4'd0;
            op_done <= 1'b0;
        end
        else
        begin
            issue_r <= start_op;
            op_done <= last_done;
            if (start_op)
            begin
                active <= 1'b1;
                cnt    <= 4'd0;
            end
            else
            begin
                if (cmd_valid)
                    cnt <= cnt + 4'd1;
                if (last_done)
                    active <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (start_op)
        begin
            op_r      <= op;
            sh        <= tx_byte;
            ack_out_r <= ack_out;
        end
        else if (cmd_valid && (op_r == eeprom_pkg::OP_WRITE))
            sh <= {sh[6:0], 1'b0};
        else if (bit_done && (op_r == eeprom_pkg::OP_READ) && (cnt <= 4'd8))
            sh <= {sh[6:0], bit_in}; // msb first
        if (bit_done && (op_r == eeprom_pkg::OP_WRITE) && (cnt == 4'd9))
            ack_in <= bit_in;
    end

endmodule

// ==== i2c_master/i2c_sequencer.sv ====
`timescale 1ns/1ps

module i2c_sequencer
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  eeprom_pkg::byte_t        wdata,
    input  logic                     op_done,
    input  eeprom_pkg::byte_t        rx_byte,
    input  logic                     ack_in,
    output logic                     busy,
    output logic                     done,
    output logic                     nack,
    output eeprom_pkg::byte_t        rdata,
    output logic                     op_valid,
    output eeprom_pkg::byte_op_e     op,
    output eeprom_pkg::byte_t        tx_byte,
    output logic                     ack_out
);

    eeprom_pkg::seq_state_e   state;
    eeprom_pkg::seq_state_e   state_nxt;
    eeprom_pkg::eeprom_addr_t addr_r;
    eeprom_pkg::byte_t        wdata_r;
    logic                     is_read;
    logic                     nack_acc;  // sticky, any missing ack
    logic                     accept;
    logic                     acked_op;
    eeprom_pkg::byte_op_e     op_nxt;
    eeprom_pkg::byte_t        tx_nxt;

    assign accept = (state == eeprom_pkg::IDLE) && (wr || rd);

    // states whose byte is acknowledged by the slave
    assign acked_op = (state == eeprom_pkg::W_CTRL) || (state == eeprom_pkg::W_ADDR) ||
                      (state == eeprom_pkg::W_DATA) || (state == eeprom_pkg::R_CTRL);

    assign ack_out = 1'b1; // single byte read always ends with master nack

    always_comb
    begin
        state_nxt = state;
        case (state)
            eeprom_pkg::IDLE:
                if (wr || rd)
                    state_nxt = eeprom_pkg::W_START;
            eeprom_pkg::W_START:
                if (op_done)
                    state_nxt = eeprom_pkg::W_CTRL;
            eeprom_pkg::W_CTRL:
                if (op_done)
                    state_nxt = eeprom_pkg::W_ADDR;
            eeprom_pkg::W_ADDR:
                if (op_done)
                    state_nxt = is_read ? eeprom_pkg::R_RESTART : eeprom_pkg::W_DATA;
            eeprom_pkg::W_DATA:
                if (op_done)
                    state_nxt = eeprom_pkg::STOP;
            eeprom_pkg::R_RESTART:
                if (op_done)
                    state_nxt = eeprom_pkg::R_CTRL;
            eeprom_pkg::R_CTRL:
                if (op_done)
                    state_nxt = eeprom_pkg::R_DATA;
            eeprom_pkg::R_DATA:
                if (op_done)
                    state_nxt = eeprom_pkg::STOP;
            eeprom_pkg::STOP:
                if (op_done)
                    state_nxt = eeprom_pkg::DONE;
            default:
                state_nxt = eeprom_pkg::IDLE;
        endcase
    end

    // operation issued on entry to the next state
    always_comb
    begin
        op_nxt = eeprom_pkg::OP_WRITE;
        tx_nxt = 8'hff;
        case (state_nxt)
            eeprom_pkg::W_START,
            eeprom_pkg::R_RESTART:
                op_nxt = eeprom_pkg::OP_START;
            eeprom_pkg::W_CTRL:
                tx_nxt = {eeprom_pkg::DEVICE_TYPE, addr_r[10:8], 1'b0};
            eeprom_pkg::W_ADDR:
                tx_nxt = addr_r[7:0];
            eeprom_pkg::W_DATA:
                tx_nxt = wdata_r;
            eeprom_pkg::R_CTRL:
                tx_nxt = {eeprom_pkg::DEVICE_TYPE, addr_r[10:8], 1'b1};
            eeprom_pkg::R_DATA:
                op_nxt = eeprom_pkg::OP_READ;
            eeprom_pkg::STOP:
                op_nxt = eeprom_pkg::OP_STOP;
            default:
                op_nxt = eeprom_pkg::OP_WRITE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= eeprom_pkg::IDLE;
            busy     <= 1'b0;
            done     <= 1'b0;
            nack     <= 1'b0;
            nack_acc <= 1'b0;
            op_valid <= 1'b0;
        end
        else
        begin
            state    <= state_nxt;
            busy     <= (state_nxt != eeprom_pkg::IDLE);
            done     <= (state_nxt == eeprom_pkg::DONE);
            op_valid <= (state_nxt != state) && (state_nxt != eeprom_pkg::DONE) &&
                        (state_nxt != eeprom_pkg::IDLE);
            if (accept)
                nack_acc <= 1'b0;
            else if (op_done && acked_op)
                nack_acc <= nack_acc | ack_in; // high ack bit = not acknowledged
            if (state_nxt == eeprom_pkg::DONE)
                nack <= nack_acc;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_r  <= addr;
            wdata_r <= wdata;
            is_read <= ~wr; // wr wins when both are set
        end
        op      <= op_nxt;
        tx_byte <= tx_nxt;
        if (op_done && (state == eeprom_pkg::R_DATA))
            rdata <= rx_byte;
    end

endmodule

// ==== verilog/eeprom_ctrl.sv ====
`timescale 1ns/1ps

module eeprom_ctrl #(
    parameter int CLKS_PER_QUARTER = 2
)
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  eeprom_pkg::byte_t        wdata,
    output eeprom_pkg::byte_t        rdata,
    output logic                     busy,
    output logic                     done,
    output logic                     nack,
    output logic                     scl,
    inout  wire                      sda
);

    // sequencer to byte engine
    logic                 op_valid;
    eeprom_pkg::byte_op_e op;
    eeprom_pkg::byte_t    tx_byte;
    logic                 ack_out;
    logic                 op_done;
    eeprom_pkg::byte_t    rx_byte;
    logic                 ack_in;

    // byte engine to bit engine
    logic                 cmd_valid;
    eeprom_pkg::bit_cmd_e cmd;
    logic                 bit_out;
    logic                 bit_done;
    logic                 bit_in;

    i2c_sequencer sequencer_i
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .op_done  (op_done),
        .rx_byte  (rx_byte),
        .ack_in   (ack_in),
        .busy     (busy),
        .done     (done),
        .nack     (nack),
        .rdata    (rdata),
        .op_valid (op_valid),
        .op       (op),
        .tx_byte  (tx_byte),
        .ack_out  (ack_out)
    );

    i2c_byte_engine byte_engine_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .op_valid  (op_valid),
        .op        (op),
        .tx_byte   (tx_byte),
        .ack_out   (ack_out),
        .bit_done  (bit_done),
        .bit_in    (bit_in),
        .op_done   (op_done),
        .rx_byte   (rx_byte),
        .ack_in    (ack_in),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .bit_out   (bit_out)
    );

    i2c_bit_engine #(
        .CLKS_PER_QUARTER (CLKS_PER_QUARTER)
    ) bit_engine_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .bit_out   (bit_out),
        .bit_done  (bit_done),
        .bit_in    (bit_in),
        .scl       (scl),
        .sda       (sda)
    );

endmodule

// ==== test/eeprom_model.sv ====
`timescale 1ns/1ps

module eeprom_model
(
    input  logic scl,
    inout  wire  sda,
    input  logic nack_mode  // withhold every acknowledge
);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_CTRL,
        S_ADDR,
        S_WDATA,
        S_RDATA
    } slave_state_e;

    logic [7:0]   mem [0:2047];
    slave_state_e state;
    slave_state_e state_after_ack;
    logic [3:0]   bit_cnt;       // bits seen in the current byte
    logic [7:0]   rx;
    logic [7:0]   tx;
    logic [2:0]   block;
    logic [7:0]   word;
    logic         master_acked;
    logic         sda_low;
    logic         scl_q;
    logic         sda_q;

    assign sda = sda_low ? 1'b0 : 1'bz;

    initial
    begin
        // fill depends on the whole address
        for (int i = 0; i < 2048; i++)
            mem[i] = i[7:0] ^ {i[10:8], i[10:8], i[10:9]};
        state   = S_IDLE;
        bit_cnt = 4'd0;
        sda_low = 1'b0;
    end

    always @(scl or sda)
    begin
        if ((scl === 1'b1) && (scl_q === 1'b1) && (sda_q === 1'b1) && (sda === 1'b0))
        begin
            state   = S_CTRL; // start or repeated start
            bit_cnt = 4'd0;
            sda_low = 1'b0;
        end
        else if ((scl === 1'b1) && (scl_q === 1'b1) && (sda_q === 1'b0) && (sda === 1'b1))
            state = S_IDLE; // stop
        else if ((scl === 1'b1) && (scl_q === 1'b0) && (state != S_IDLE))
        begin
            bit_cnt = bit_cnt + 4'd1;
            if (bit_cnt == 4'd9)
                master_acked = (sda === 1'b0);
            else
                rx = {rx[6:0], (sda === 1'b0) ? 1'b0 : 1'b1};
        end
        else if ((scl === 1'b0) && (scl_q === 1'b1) && (state != S_IDLE))
        begin
            if (bit_cnt == 4'd8)
            begin
                case (state)
                    S_CTRL:
                        if (!nack_mode && (rx[7:4] == eeprom_pkg::DEVICE_TYPE))
                        begin
                            block           = rx[3:1];
                            sda_low         = 1'b1;
                            state_after_ack = rx[0] ? S_RDATA : S_ADDR;
                        end
                        else
                            state_after_ack = S_IDLE;
                    S_ADDR:
                    begin
                        word            = rx;
                        sda_low         = 1'b1;
                        state_after_ack = S_WDATA;
                    end
                    S_WDATA:
                    begin
                        mem[{block, word}] = rx;
                        word               = word + 8'd1;
                        sda_low            = 1'b1;
                        state_after_ack    = S_WDATA;
                    end
                    default:
                        sda_low = 1'b0; // master owns the ack bit
                endcase
            end
            else if (bit_cnt == 4'd9)
            begin
                bit_cnt = 4'd0;
                sda_low = 1'b0;
                if (state != S_RDATA)
                    state = state_after_ack;
                else if (master_acked)
                    word = word + 8'd1;
                else
                    state = S_IDLE;
                if (state == S_RDATA)
                begin
                    tx      = mem[{block, word}];
                    sda_low = !tx[7];
                end
            end
            else if ((state == S_RDATA) && (bit_cnt != 4'd0))
                sda_low = !tx[4'd7 - bit_cnt]; // msb first
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// ==== test/eeprom_ctrl_props.sv ====
`timescale 1ns/1ps

module eeprom_ctrl_props
(
    input logic                 CLK,
    input logic                 RESET,
    input logic                 scl,
    input logic                 sda,
    input logic                 active,
    input logic                 cmd_valid,
    input eeprom_pkg::bit_cmd_e cmd_r,
    input logic                 bit_done
);

    // outside start and stop, sda only moves while scl is low
    assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && ((cmd_r == eeprom_pkg::CMD_WRITE) ||
                               (cmd_r == eeprom_pkg::CMD_READ))) |-> $stable(sda))
        else $error("sda changed while scl was high during a data bit");

    assert property (@(posedge CLK) disable iff (RESET) bit_done |=> !bit_done)
        else $error("bit_done held for more than one cycle");

    assert property (@(posedge CLK) disable iff (RESET) (active && !bit_done) |-> !cmd_valid)
        else $error("cmd_valid arrived before bit_done of the previous command");

endmodule

bind i2c_bit_engine eeprom_ctrl_props props_i
(
    .CLK       (CLK),
    .RESET     (RESET),
    .scl       (scl),
    .sda       (sda),
    .active    (active),
    .cmd_valid (cmd_valid),
    .cmd_r     (cmd_r),
    .bit_done  (bit_done)
);

// ==== test/eeprom_ctrl_tb.sv ====
`timescale 1ns/1ps

module eeprom_ctrl_tb;

    localparam int CLKS_PER_QUARTER = 2;
    localparam int TIMEOUT_CYCLES   = 2000;

    logic                     CLK = 1'b0;
    logic                     RESET;
    logic                     wr;
    logic                     rd;
    eeprom_pkg::eeprom_addr_t addr;
    eeprom_pkg::byte_t        wdata;
    eeprom_pkg::byte_t        rdata;
    logic                     busy;
    logic                     done;
    logic                     nack;
    logic                     scl;
    logic                     nack_mode;
    wire                      sda;

    pullup (sda);

    eeprom_ctrl #(
        .CLKS_PER_QUARTER (CLKS_PER_QUARTER)
    ) eeprom_ctrl_i
    (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .busy  (busy),
        .done  (done),
        .nack  (nack),
        .scl   (scl),
        .sda   (sda)
    );

    eeprom_model model_i
    (
        .scl       (scl),
        .sda       (sda),
        .nack_mode (nack_mode)
    );

    always #2 CLK = ~CLK;

    task automatic report_failure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
            report_failure();
        end
    endtask

    task automatic wait_not_busy();
        int cycles;
        cycles = 0;
        while ((busy !== 1'b0) && (cycles < TIMEOUT_CYCLES))
        begin
            @(negedge CLK);
            cycles++;
        end
        if (busy !== 1'b0)
        begin
            $display("timeout: busy did not go low within %0d cycles", TIMEOUT_CYCLES);
            report_failure();
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while ((done !== 1'b1) && (cycles < TIMEOUT_CYCLES))
        begin
            @(negedge CLK);
            cycles++;
        end
        if (done !== 1'b1)
        begin
            $display("timeout: done did not arrive within %0d cycles", TIMEOUT_CYCLES);
            report_failure();
        end
    endtask

    task automatic run_vector(input logic [7:0] op_c, input eeprom_pkg::eeprom_addr_t a,
                              input eeprom_pkg::byte_t d, input eeprom_pkg::byte_t exp_rdata,
                              input logic exp_nack);
        logic is_read;
        is_read   = (op_c == "R") || (op_c == "J");
        nack_mode = exp_nack;
        wait_not_busy();
        addr  = a;
        wdata = d;
        wr    = !is_read;
        rd    = is_read || (op_c == "B");
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        if ((op_c == "I") || (op_c == "J"))
        begin
            check_value("busy", busy, 1);
            wr    = 1'b1; // should be dropped
            wdata = (op_c == "I") ? ~d : d;
            @(negedge CLK);
            wr = 1'b0;
        end
        wait_done();
        check_value("nack", nack, exp_nack);
        if (is_read)
            check_value("rdata", rdata, exp_rdata);
        @(negedge CLK);
        check_value("done", done, 0);
    endtask

    initial
    begin
        int                       fd;
        int                       c;
        int                       n;
        int                       count;
        eeprom_pkg::eeprom_addr_t v_addr;
        eeprom_pkg::byte_t        v_wdata;
        eeprom_pkg::byte_t        v_rdata;
        logic                     v_nack;

        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wdata     = '0;
        nack_mode = 1'b0;
        count     = 0;
        fd = $fopen("test/eeprom_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open test/eeprom_vectors.txt");
            report_failure();
        end
        repeat (4) @(negedge CLK);
        RESET = 1'b0;

        // quiet bus before the first request
        repeat (8)
        begin
            @(negedge CLK);
            check_value("busy", busy, 0);
            check_value("done", done, 0);
            check_value("scl", scl, 1);
            check_value("sda", sda, 1);
        end

        while (!$feof(fd))
        begin
            c = $fgetc(fd);
            if (c == "#")
            begin
                while ((c != "\n") && (c != -1))
                    c = $fgetc(fd);
            end
            else if ((c == "W") || (c == "R") || (c == "B") || (c == "I") || (c == "J"))
            begin
                n = $fscanf(fd, "%h %h %h %h", v_addr, v_wdata, v_rdata, v_nack);
                if (n != 4)
                begin
                    $display("malformed vector line after operation %c", c);
                    report_failure();
                end
                run_vector(8'(c), v_addr, v_wdata, v_rdata, v_nack);
                count++;
            end
            else if ((c != " ") && (c != "\n") && (c != "\r") && (c != "\t") && (c != -1))
            begin
                $display("unknown operation code in the vector file");
                report_failure();
            end
        end
        $fclose(fd);

        if (count == 0)
        begin
            $display("no vectors were read from the vector file");
            report_failure();
        end
        else
        begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== test/eeprom_vectors.txt ====
# op addr wdata rdata nack (hex) W write, R read, B wr and rd together,
# I write plus a wr of ~wdata while busy, J read plus a wr of wdata while busy
W 005 3c 00 0
R 005 00 3c 0
W 705 a7 00 0
W 305 19 00 0
R 705 00 a7 0
R 305 00 19 0
R 005 00 3c 0
W 005 55 00 1
R 005 00 ff 1
R 005 00 3c 0
I 2f0 81 00 0
R 2f0 00 81 0
J 2f0 e2 81 0
R 2f0 00 81 0
B 4aa 6d 00 0
R 4aa 00 6d 0

// ==== flist.f ====
common/eeprom_pkg.sv
i2c_master/i2c_bit_engine.sv
i2c_master/i2c_byte_engine.sv
i2c_master/i2c_sequencer.sv
verilog/eeprom_ctrl.sv
test/eeprom_model.sv
test/eeprom_ctrl_props.sv
test/eeprom_ctrl_tb.sv
